/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_cart_top
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* address/address.sv */
`timescale 1ns/1ps

module address (
  // configuration from the mcu
  input  logic [2:0]                  mapper,
  input  logic [7:0]                  features,
  input  logic [cart_pkg::addr_w-1:0] rom_mask,
  input  logic [cart_pkg::addr_w-1:0] sram_mask,
  // captured snes access
  input  logic [cart_pkg::addr_w-1:0] acc_addr,
  input  logic [cart_pkg::pa_w-1:0]   acc_pa,
  // memory side result
  output logic [cart_pkg::addr_w-1:0] map_addr,
  output logic                        is_rom,
  output logic                        is_saveram,
  // peripheral windows
  output logic                        msu_hit,
  output logic                        srtc_hit,
  output logic                        r213f_hit,
  output logic                        snescmd_rd_hit,
  output logic                        snescmd_wr_hit
);

  // mapper code is one we decode
  logic        map_ok;
  // save ram windows per mapper family
  logic        hi_window;
  logic        lo_window;
  logic        sram_window;
  // menu offset relative to 6000
  logic [14:0] menu_off;
  // candidate addresses
  logic [cart_pkg::addr_w-1:0] hi_sram_addr;
  logic [cart_pkg::addr_w-1:0] lo_sram_addr;
  logic [cart_pkg::addr_w-1:0] menu_sram_addr;
  logic [cart_pkg::addr_w-1:0] hi_rom_addr;
  logic [cart_pkg::addr_w-1:0] lo_rom_addr;
  logic [cart_pkg::addr_w-1:0] ex_rom_addr;
  logic [cart_pkg::addr_w-1:0] menu_rom_addr;
  // selected by mapper
  logic [cart_pkg::addr_w-1:0] sram_addr;
  logic [cart_pkg::addr_w-1:0] rom_addr;

  ////////////////////
  // save ram windows
  ////////////////////

  // hirom style: banks 20-3f and a0-bf, offset 6000-7fff
  assign hi_window = ~acc_addr[22] & acc_addr[21] & ~acc_addr[15]
                     & acc_addr[14] & acc_addr[13];

  // lorom: banks 70-7d and f0-fd
  // upper half only free for rom below 32 mbit
  assign lo_window = (&acc_addr[22:20]) & (acc_addr[19:16] < 4'hE)
                     & (~acc_addr[15] | ~rom_mask[21]);

  ////////////////////
  // address forming
  ////////////////////

  // 8k per bank in the hirom window
  assign hi_sram_addr = cart_pkg::saveram_base
                        + ({6'b0, acc_addr[20:16], acc_addr[12:0]} & sram_mask);
  // 32k per bank in lorom
  assign lo_sram_addr = cart_pkg::saveram_base
                        + ({4'b0, acc_addr[20:16], acc_addr[14:0]} & sram_mask);

  assign menu_off       = acc_addr[14:0] - cart_pkg::menu_sram_offset;
  assign menu_sram_addr = cart_pkg::menu_sram_base + ({9'b0, menu_off} & sram_mask);

  // linear rom, a23 mirrors
  assign hi_rom_addr   = {1'b0, acc_addr[22:0]} & rom_mask;
  // drop a15 for 32k lorom banks
  assign lo_rom_addr   = {2'b0, acc_addr[22:16], acc_addr[14:0]} & rom_mask;
  // banks c0-ff first, then 40-7d
  assign ex_rom_addr   = {1'b0, ~acc_addr[23], acc_addr[21:0]} & rom_mask;
  assign menu_rom_addr = hi_rom_addr + cart_pkg::menu_rom_base;

  ////////////////////
  // mapper select
  ////////////////////

  always_comb begin
    map_ok      = 1'b1;
    sram_window = 1'b0;
    sram_addr   = '0;
    rom_addr    = '0;
    case (mapper)
      cart_pkg::map_hirom: begin
        sram_window = hi_window;
        sram_addr   = hi_sram_addr;
        rom_addr    = hi_rom_addr;
      end
      cart_pkg::map_lorom: begin
        sram_window = lo_window;
        sram_addr   = lo_sram_addr;
        rom_addr    = lo_rom_addr;
      end
      cart_pkg::map_exhirom: begin
        sram_window = hi_window;
        sram_addr   = hi_sram_addr;
        rom_addr    = ex_rom_addr;
      end
      cart_pkg::map_menu: begin
        // same window as hirom
        sram_window = hi_window;
        sram_addr   = menu_sram_addr;
        rom_addr    = menu_rom_addr;
      end
      default: begin
        // bsx, sufami, interleaved not handled
        map_ok = 1'b0;
      end
    endcase
  end

  // no save ram when mask bit 0 is clear
  assign is_saveram = sram_mask[0] & sram_window;
  // upper half of every bank plus banks 40-7f
  assign is_rom     = map_ok & (acc_addr[22] | acc_addr[15]);
  assign map_addr   = is_saveram ? sram_addr : rom_addr;

  ////////////////////
  // peripherals
  ////////////////////

  // msu1 regs at 2000-2007 in system banks
  assign msu_hit = features[cart_pkg::feat_msu1] & ~acc_addr[22]
                   & (acc_addr[15:3] == 13'h0400);
  // s-rtc at 2800-2801
  assign srtc_hit = features[cart_pkg::feat_srtc] & ~acc_addr[22]
                    & (acc_addr[15:1] == 15'h1400);
  // ppu2 status override
  assign r213f_hit = features[cart_pkg::feat_213f] & (acc_pa == 8'h3f);
  // b-bus 21f0-21ff readback
  assign snescmd_rd_hit = (acc_pa[7:4] == 4'hF);
  // write window cccc0-ccccf
  assign snescmd_wr_hit = (acc_addr[23:4] == 20'hCCCCC);

endmodule

/* common/cart_pkg.sv */
package cart_pkg;

  ////////////////////
  // bus widths
  ////////////////////

  // snes cpu address bus a23..a0
  localparam int addr_w = 24;
  // b-bus peripheral address pa7..pa0
  localparam int pa_w = 8;
  // snes data bus
  localparam int data_w = 8;

  ////////////////////
  // mapper codes
  ////////////////////

  // as detected by the microcontroller
  localparam logic [2:0] map_hirom = 3'd0;
  localparam logic [2:0] map_lorom = 3'd1;
  // 48 to 64 mbit hirom variant
  localparam logic [2:0] map_exhirom = 3'd2;
  // menu rom sits in the upper part of memory
  localparam logic [2:0] map_menu = 3'd7;
  // codes 3 to 6 are not decoded here and map nothing

  ////////////////////
  // feature bits
  ////////////////////

  // bit positions in the 8-bit feature word
  // bits 0 and 1 are unused in this design
  localparam int feat_srtc = 2;
  localparam int feat_msu1 = 3;
  localparam int feat_213f = 4;

  ////////////////////
  // memory layout
  ////////////////////

  // save ram base for hirom, lorom, exhirom
  localparam logic [addr_w-1:0] saveram_base = 24'hE00000;
  // menu save ram lives near the top
  localparam logic [addr_w-1:0] menu_sram_base = 24'hFF0000;
  // menu rom image base
  localparam logic [addr_w-1:0] menu_rom_base = 24'hC00000;
  // menu save ram window starts at offset 6000
  localparam logic [14:0] menu_sram_offset = 15'h6000;

  ////////////////////
  // config registers
  ////////////////////

  // cfg_sel values on the microcontroller port
  localparam logic [1:0] cfg_mapper = 2'd0;
  localparam logic [1:0] cfg_features = 2'd1;
  localparam logic [1:0] cfg_rom_mask = 2'd2;
  localparam logic [1:0] cfg_sram_mask = 2'd3;

endpackage

/* logic/access_dispatch.sv */
`timescale 1ns/1ps

module access_dispatch (
  input  logic                        clk,
  input  logic                        rst,
  // decoded access
  input  logic                        acc_valid,
  input  logic                        acc_we,
  input  logic [cart_pkg::data_w-1:0] acc_wdata,
  input  logic [cart_pkg::addr_w-1:0] map_addr,
  input  logic                        is_rom,
  input  logic                        is_saveram,
  input  logic                        msu_hit,
  input  logic                        srtc_hit,
  input  logic                        r213f_hit,
  input  logic                        snescmd_rd_hit,
  input  logic                        snescmd_wr_hit,
  // memory request port
  input  logic                        mem_ready,
  output logic                        mem_valid,
  output logic [cart_pkg::addr_w-1:0] mem_addr,
  output logic                        mem_we,
  output logic [cart_pkg::data_w-1:0] mem_wdata,
  // select pulses
  output logic                        msu_sel,
  output logic                        srtc_sel,
  output logic                        r213f_sel,
  output logic                        snescmd_rd_sel,
  output logic                        snescmd_wr_sel,
  output logic                        overrun
);

  // access that needs the memory port
  logic mem_worthy;
  // request still waiting for ready
  logic pending;
  // start a new request this edge
  logic take;

  // save ram either way, rom only on reads
  assign mem_worthy = acc_valid & (is_saveram | (is_rom & ~acc_we));
  assign pending    = mem_valid & ~mem_ready;
  assign take       = mem_worthy & ~pending;

  ////////////////////
  // control
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid      <= 1'b0;
      overrun        <= 1'b0;
      msu_sel        <= 1'b0;
      srtc_sel       <= 1'b0;
      r213f_sel      <= 1'b0;
      snescmd_rd_sel <= 1'b0;
      snescmd_wr_sel <= 1'b0;
    end else begin
      // back to back allowed on the accepting edge
      if (take) begin
        mem_valid <= 1'b1;
      end else if (mem_ready) begin
        mem_valid <= 1'b0;
      end
      // dropped access, sticky
      if (mem_worthy & pending) begin
        overrun <= 1'b1;
      end
      // selects ignore back-pressure
      msu_sel        <= acc_valid & msu_hit;
      srtc_sel       <= acc_valid & srtc_hit;
      r213f_sel      <= acc_valid & r213f_hit;
      snescmd_rd_sel <= acc_valid & snescmd_rd_hit;
      snescmd_wr_sel <= acc_valid & snescmd_wr_hit;
    end
  end

  // request payload, frozen while pending
  always_ff @(posedge clk) begin
    if (take) begin
      mem_addr  <= map_addr;
      mem_we    <= acc_we;
      mem_wdata <= acc_wdata;
    end
  end

endmodule

/* logic/bus_capture.sv */
`timescale 1ns/1ps

module bus_capture (
  input  logic                        clk,
  input  logic                        rst,
  // asynchronous snes side
  input  logic [cart_pkg::addr_w-1:0] snes_addr,
  input  logic [cart_pkg::pa_w-1:0]   snes_pa,
  input  logic [cart_pkg::data_w-1:0] snes_wdata,
  input  logic                        snes_rd,
  input  logic                        snes_wr,
  // one captured access per strobe
  output logic                        acc_valid,
  output logic [cart_pkg::addr_w-1:0] acc_addr,
  output logic [cart_pkg::pa_w-1:0]   acc_pa,
  output logic                        acc_we,
  output logic [cart_pkg::data_w-1:0] acc_wdata
);

  // either strobe starts an access
  logic strobe;
  // two sync stages then the edge register
  logic strb_s1;
  logic strb_s2;
  logic strb_q;
  // write strobe follows the same path
  logic wr_s1;
  logic wr_s2;
  // rising edge of the synchronized strobe
  logic rise;

  assign strobe = snes_rd | snes_wr;
  // held strobe stays high in strb_q so no repeat
  assign rise = strb_s2 & ~strb_q;

  ////////////////////
  // synchronizer
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      strb_s1   <= 1'b0;
      strb_s2   <= 1'b0;
      strb_q    <= 1'b0;
      wr_s1     <= 1'b0;
      wr_s2     <= 1'b0;
      acc_valid <= 1'b0;
    end else begin
      strb_s1   <= strobe;
      strb_s2   <= strb_s1;
      strb_q    <= strb_s2;
      wr_s1     <= snes_wr;
      wr_s2     <= wr_s1;
      // single cycle, snes bus cannot wait
      acc_valid <= rise;
    end
  end

  ////////////////////
  // access capture
  ////////////////////

  // address and data settled long before the third edge
  always_ff @(posedge clk) begin
    if (rise) begin
      acc_addr  <= snes_addr;
      acc_pa    <= snes_pa;
      acc_wdata <= snes_wdata;
      acc_we    <= wr_s2;
    end
  end

endmodule

/* logic/cart_top.sv */
`timescale 1ns/1ps

module cart_top (
  input  logic                        clk,
  input  logic                        rst,
  // snes bus
  input  logic [cart_pkg::addr_w-1:0] snes_addr,
  input  logic [cart_pkg::pa_w-1:0]   snes_pa,
  input  logic [cart_pkg::data_w-1:0] snes_wdata,
  input  logic                        snes_rd,
  input  logic                        snes_wr,
  // mcu config port
  input  logic                        cfg_we,
  input  logic [1:0]                  cfg_sel,
  input  logic [cart_pkg::addr_w-1:0] cfg_wdata,
  // memory port
  input  logic                        mem_ready,
  output logic                        mem_valid,
  output logic [cart_pkg::addr_w-1:0] mem_addr,
  output logic                        mem_we,
  output logic [cart_pkg::data_w-1:0] mem_wdata,
  // peripheral selects
  output logic                        msu_sel,
  output logic                        srtc_sel,
  output logic                        r213f_sel,
  output logic                        snescmd_rd_sel,
  output logic                        snescmd_wr_sel,
  output logic                        overrun
);

  // config
  logic [2:0]                  mapper;
  logic [7:0]                  features;
  logic [cart_pkg::addr_w-1:0] rom_mask;
  logic [cart_pkg::addr_w-1:0] sram_mask;
  // captured access
  logic                        acc_valid;
  logic [cart_pkg::addr_w-1:0] acc_addr;
  logic [cart_pkg::pa_w-1:0]   acc_pa;
  logic                        acc_we;
  logic [cart_pkg::data_w-1:0] acc_wdata;
  // decode result
  logic [cart_pkg::addr_w-1:0] map_addr;
  logic                        is_rom;
  logic                        is_saveram;
  logic                        msu_hit;
  logic                        srtc_hit;
  logic                        r213f_hit;
  logic                        snescmd_rd_hit;
  logic                        snescmd_wr_hit;

  config_regs u_config_regs (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_sel   (cfg_sel),
    .cfg_wdata (cfg_wdata),
    .mapper    (mapper),
    .features  (features),
    .rom_mask  (rom_mask),
    .sram_mask (sram_mask)
  );

  // three edges from strobe to acc_valid
  bus_capture u_bus_capture (
    .clk        (clk),
    .rst        (rst),
    .snes_addr  (snes_addr),
    .snes_pa    (snes_pa),
    .snes_wdata (snes_wdata),
    .snes_rd    (snes_rd),
    .snes_wr    (snes_wr),
    .acc_valid  (acc_valid),
    .acc_addr   (acc_addr),
    .acc_pa     (acc_pa),
    .acc_we     (acc_we),
    .acc_wdata  (acc_wdata)
  );

  // purely combinational
  address u_address (
    .mapper         (mapper),
    .features       (features),
    .rom_mask       (rom_mask),
    .sram_mask      (sram_mask),
    .acc_addr       (acc_addr),
    .acc_pa         (acc_pa),
    .map_addr       (map_addr),
    .is_rom         (is_rom),
    .is_saveram     (is_saveram),
    .msu_hit        (msu_hit),
    .srtc_hit       (srtc_hit),
    .r213f_hit      (r213f_hit),
    .snescmd_rd_hit (snescmd_rd_hit),
    .snescmd_wr_hit (snescmd_wr_hit)
  );

  // fourth edge registers the outputs
  access_dispatch u_access_dispatch (
    .clk            (clk),
    .rst            (rst),
    .acc_valid      (acc_valid),
    .acc_we         (acc_we),
    .acc_wdata      (acc_wdata),
    .map_addr       (map_addr),
    .is_rom         (is_rom),
    .is_saveram     (is_saveram),
    .msu_hit        (msu_hit),
    .srtc_hit       (srtc_hit),
    .r213f_hit      (r213f_hit),
    .snescmd_rd_hit (snescmd_rd_hit),
    .snescmd_wr_hit (snescmd_wr_hit),
    .mem_ready      (mem_ready),
    .mem_valid      (mem_valid),
    .mem_addr       (mem_addr),
    .mem_we         (mem_we),
    .mem_wdata      (mem_wdata),
    .msu_sel        (msu_sel),
    .srtc_sel       (srtc_sel),
    .r213f_sel      (r213f_sel),
    .snescmd_rd_sel (snescmd_rd_sel),
    .snescmd_wr_sel (snescmd_wr_sel),
    .overrun        (overrun)
  );

endmodule

/* logic/config_regs.sv */
`timescale 1ns/1ps

module config_regs (
  input  logic                        clk,
  input  logic                        rst,
  // microcontroller write port
  input  logic                        cfg_we,
  input  logic [1:0]                  cfg_sel,
  input  logic [cart_pkg::addr_w-1:0] cfg_wdata,
  // current mapping setup
  output logic [2:0]                  mapper,
  output logic [7:0]                  features,
  output logic [cart_pkg::addr_w-1:0] rom_mask,
  output logic [cart_pkg::addr_w-1:0] sram_mask
);

  ////////////////////
  // register file
  ////////////////////

  // one register per cfg_sel value
  // a write takes effect on the next edge
  always_ff @(posedge clk) begin
    if (rst) begin
      // menu mapper until the mcu says otherwise
      mapper    <= cart_pkg::map_menu;
      features  <= '0;
      rom_mask  <= '0;
      sram_mask <= '0;
    end else if (cfg_we) begin
      case (cfg_sel)
        cart_pkg::cfg_mapper: begin
          // only the low 3 bits matter
          mapper <= cfg_wdata[2:0];
        end
        cart_pkg::cfg_features: begin
          // feature enables in the low byte
          features <= cfg_wdata[7:0];
        end
        cart_pkg::cfg_rom_mask: begin
          rom_mask <= cfg_wdata;
        end
        cart_pkg::cfg_sram_mask: begin
          // bit 0 doubles as save ram present
          sram_mask <= cfg_wdata;
        end
      endcase
    end
  end

endmodule

/* tb/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic rst
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset over the first 8 rising edges, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

/* tb/tb_cart_top.sv */
`timescale 1ns/1ps

module tb_cart_top;

  // tests take about 900 cycles, so this leaves a wide margin
  localparam int max_cycles = 4000;

  logic        clk;
  logic        rst;
  logic [23:0] snes_addr;
  logic [7:0]  snes_pa;
  logic [7:0]  snes_wdata;
  logic        snes_rd;
  logic        snes_wr;
  logic        cfg_we;
  logic [1:0]  cfg_sel;
  logic [23:0] cfg_wdata;
  logic        mem_ready;
  logic        mem_valid;
  logic [23:0] mem_addr;
  logic        mem_we;
  logic [7:0]  mem_wdata;
  logic        msu_sel;
  logic        srtc_sel;
  logic        r213f_sel;
  logic        snescmd_rd_sel;
  logic        snescmd_wr_sel;
  logic        overrun;

  // shadow of the config the DUT should hold
  logic [2:0]  cur_mapper;
  logic [7:0]  cur_features;
  logic [23:0] cur_rom_mask;
  logic [23:0] cur_sram_mask;
  // expected result of the access in flight
  logic        armed;
  int          rise_cycle;
  logic        exp_req;
  logic [23:0] exp_addr;
  logic        exp_we;
  logic [7:0]  exp_wdata;
  logic [4:0]  exp_sel;
  // bookkeeping, one set per process
  int          cycle = 0;
  int          cmp_errs;
  int          cmp_checks;
  int          main_errs;
  int          main_checks;
  int          errs_base;
  int          tests_run;
  string       cur_test;
  logic [15:0] lfsr = 16'd54;
  logic [2:0]  mapper_list [0:3] = '{cart_pkg::map_hirom, cart_pkg::map_lorom,
                                     cart_pkg::map_exhirom, cart_pkg::map_menu};

  clock_gen u_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  cart_top UUT (
    .clk            (clk),
    .rst            (rst),
    .snes_addr      (snes_addr),
    .snes_pa        (snes_pa),
    .snes_wdata     (snes_wdata),
    .snes_rd        (snes_rd),
    .snes_wr        (snes_wr),
    .cfg_we         (cfg_we),
    .cfg_sel        (cfg_sel),
    .cfg_wdata      (cfg_wdata),
    .mem_ready      (mem_ready),
    .mem_valid      (mem_valid),
    .mem_addr       (mem_addr),
    .mem_we         (mem_we),
    .mem_wdata      (mem_wdata),
    .msu_sel        (msu_sel),
    .srtc_sel       (srtc_sel),
    .r213f_sel      (r213f_sel),
    .snescmd_rd_sel (snescmd_rd_sel),
    .snescmd_wr_sel (snescmd_wr_sel),
    .overrun        (overrun)
  );

  ////////////////////
  // random source
  ////////////////////

  // 16-bit fibonacci, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one step per bit taken
  function automatic logic [23:0] rand_bits(input int n);
    logic [23:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[22:0], lfsr[0]};
    end
    return v;
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  // result word: request, memory address, then msu srtc 213f cmd_rd cmd_wr
  function automatic logic [29:0] ref_decode(input logic [2:0] m, input logic [7:0] f,
                                             input logic [23:0] rmask,
                                             input logic [23:0] smask,
                                             input logic [23:0] a, input logic [7:0] pa,
                                             input logic we);
    logic        known;
    logic        hi_style;
    logic        rom;
    logic        sram;
    logic        req;
    logic [23:0] off;
    logic [23:0] base;
    logic [23:0] ma;
    logic [4:0]  sel;
    known = (m == cart_pkg::map_hirom) || (m == cart_pkg::map_lorom)
            || (m == cart_pkg::map_exhirom) || (m == cart_pkg::map_menu);
    hi_style = (m == cart_pkg::map_hirom) || (m == cart_pkg::map_exhirom)
               || (m == cart_pkg::map_menu);
    rom  = known && (a[22] || a[15]);
    sram = 1'b0;
    if (hi_style) begin
      sram = !a[22] && a[21] && !a[15] && a[14] && a[13];
    end
    if (m == cart_pkg::map_lorom) begin
      sram = (a[22:20] == 3'b111) && (a[19:16] < 4'hE) && (!a[15] || !rmask[21]);
    end
    sram = sram && smask[0];
    ma   = '0;
    if (sram) begin
      if (m == cart_pkg::map_lorom) begin
        off  = {4'h0, a[20:16], a[14:0]};
        base = 24'hE00000;
      end else if (m == cart_pkg::map_menu) begin
        off  = {9'h0, a[14:0] - 15'h6000};
        base = 24'hFF0000;
      end else begin
        off  = {6'h0, a[20:16], a[12:0]};
        base = 24'hE00000;
      end
      ma = base + (off & smask);
    end else begin
      case (m)
        cart_pkg::map_hirom:   ma = {1'b0, a[22:0]} & rmask;
        cart_pkg::map_lorom:   ma = {2'b00, a[22:16], a[14:0]} & rmask;
        cart_pkg::map_exhirom: ma = {1'b0, ~a[23], a[21:0]} & rmask;
        cart_pkg::map_menu:    ma = ({1'b0, a[22:0]} & rmask) + 24'hC00000;
        default:               ma = '0;
      endcase
    end
    // msu 2000-2007, s-rtc 2800-2801
    sel[4] = f[3] && !a[22] && ({a[15:3], 3'b000} == 16'h2000);
    sel[3] = f[2] && !a[22] && ({a[15:1], 1'b0} == 16'h2800);
    sel[2] = f[4] && (pa == 8'h3f);
    sel[1] = (pa[7:4] == 4'hF);
    sel[0] = (a[23:4] == 20'hCCCCC);
    req    = sram || (rom && !we);
    return {req, ma, sel};
  endfunction

  ////////////////////
  // reporting
  ////////////////////

  task automatic flag_mismatch(input string what, input logic [23:0] expected,
                               input logic [23:0] actual);
    $display("ERR %s: %s expected %h actual %h", cur_test, what, expected, actual);
  endtask

  task automatic flag_problem(input string msg);
    $display("%s: %s", cur_test, msg);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    errs_base = main_errs + cmp_errs;
  endtask

  task automatic end_test;
    int n;
    n = main_errs + cmp_errs - errs_base;
    tests_run++;
    if (n == 0) begin
      $display("%s: ok", cur_test);
    end else begin
      $display("%s: %0d errors", cur_test, n);
    end
  endtask

  ////////////////////
  // bus drivers
  ////////////////////

  // all drivers are entered on a falling edge
  task automatic write_cfg(input logic [1:0] sel, input logic [23:0] data);
    cfg_we    = 1'b1;
    cfg_sel   = sel;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
    case (sel)
      cart_pkg::cfg_mapper:   cur_mapper = data[2:0];
      cart_pkg::cfg_features: cur_features = data[7:0];
      cart_pkg::cfg_rom_mask: cur_rom_mask = data;
      default:                cur_sram_mask = data;
    endcase
  endtask

  task automatic set_config(input logic [2:0] m, input logic [7:0] f,
                            input logic [23:0] rmask, input logic [23:0] smask);
    write_cfg(cart_pkg::cfg_mapper, {21'h0, m});
    write_cfg(cart_pkg::cfg_features, {16'h0, f});
    write_cfg(cart_pkg::cfg_rom_mask, rmask);
    write_cfg(cart_pkg::cfg_sram_mask, smask);
  endtask

  // strobe 6 cycles high, 6 low
  task automatic bus_access(input logic [23:0] a, input logic [7:0] pa,
                            input logic [7:0] d, input logic wr);
    logic [29:0] r;
    r = ref_decode(cur_mapper, cur_features, cur_rom_mask, cur_sram_mask, a, pa, wr);
    exp_req    = r[29];
    exp_addr   = r[28:5];
    exp_sel    = r[4:0];
    exp_we     = wr;
    exp_wdata  = d;
    snes_addr  = a;
    snes_pa    = pa;
    snes_wdata = d;
    snes_rd    = !wr;
    snes_wr    = wr;
    rise_cycle = cycle;
    repeat (6) @(negedge clk);
    snes_rd = 1'b0;
    snes_wr = 1'b0;
    repeat (6) @(negedge clk);
  endtask

  ////////////////////
  // comparison
  ////////////////////

  // outputs settle at the rising edge, sampled on the falling one
  always @(negedge clk) begin : compare_outputs
    int         off;
    logic       want_valid;
    logic [4:0] sel_now;
    logic [4:0] want_sel;
    off        = cycle - rise_cycle;
    want_valid = exp_req && (off == 4);
    want_sel   = (off == 4) ? exp_sel : 5'b0;
    sel_now    = {msu_sel, srtc_sel, r213f_sel, snescmd_rd_sel, snescmd_wr_sel};
    if (armed && off >= 1 && off <= 11) begin
      cmp_checks++;
      if (mem_valid !== want_valid) begin
        flag_mismatch("mem_valid", 24'(want_valid), 24'(mem_valid));
        cmp_errs++;
      end
      if (sel_now !== want_sel) begin
        flag_mismatch("selects", 24'(want_sel), 24'(sel_now));
        cmp_errs++;
      end
      // payload only matters when a request is due
      if (want_valid && mem_addr !== exp_addr) begin
        flag_mismatch("mem_addr", exp_addr, mem_addr);
        cmp_errs++;
      end
      if (want_valid && mem_we !== exp_we) begin
        flag_mismatch("mem_we", 24'(exp_we), 24'(mem_we));
        cmp_errs++;
      end
      if (want_valid && exp_we && mem_wdata !== exp_wdata) begin
        flag_mismatch("mem_wdata", 24'(exp_wdata), 24'(mem_wdata));
        cmp_errs++;
      end
    end
  end

  // cycle count and run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles) begin
      $display("timeout: run still going after %0d cycles", max_cycles);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////
  // tests
  ////////////////////

  task automatic test_idle;
    start_test("idle after reset");
    repeat (10) begin
      main_checks++;
      if ({mem_valid, msu_sel, srtc_sel, r213f_sel, snescmd_rd_sel, snescmd_wr_sel,
           overrun} !== 7'b0) begin
        flag_problem("an output went active with the strobes idle");
        main_errs++;
      end
      @(negedge clk);
    end
    end_test();
  endtask

  task automatic test_rom_reads;
    logic [23:0] a;
    start_test("rom reads");
    armed = 1'b1;
    for (int i = 0; i < 4; i++) begin
      set_config(mapper_list[i], 8'h00, rand_bits(24), rand_bits(24));
      repeat (6) begin
        a = rand_bits(24);
        // upper half of a bank is always rom
        a[15] = 1'b1;
        bus_access(a, 8'(rand_bits(8)), 8'(rand_bits(8)), 1'b0);
      end
    end
    end_test();
  endtask

  task automatic test_saveram;
    logic [23:0] a;
    logic        wr;
    start_test("save ram access");
    armed = 1'b1;
    wr    = 1'b0;
    for (int i = 0; i < 4; i++) begin
      // bit 0 of the mask enables save ram
      set_config(mapper_list[i], 8'h00, rand_bits(24), rand_bits(24) | 24'h1);
      repeat (6) begin
        a = rand_bits(24);
        if (mapper_list[i] == cart_pkg::map_lorom) begin
          a[22:20] = 3'b111;
          a[19:16] = {1'b0, 3'(rand_bits(3))};
          a[15]    = 1'b0;
        end else begin
          a[22] = 1'b0;
          a[21] = 1'b1;
          a[15] = 1'b0;
          a[14] = 1'b1;
          a[13] = 1'b1;
        end
        bus_access(a, 8'h00, 8'(rand_bits(8)), wr);
        wr = !wr;
      end
    end
    end_test();
  endtask

  task automatic test_no_request;
    logic [23:0] a;
    start_test("no request");
    armed = 1'b1;
    set_config(cart_pkg::map_hirom, 8'h00, 24'hFFFFFF, 24'hFFFFFF);
    // rom writes are ignored
    repeat (2) begin
      a     = rand_bits(24);
      a[22] = 1'b1;
      a[15] = 1'b1;
      bus_access(a, 8'h00, 8'(rand_bits(8)), 1'b1);
    end
    // code 3 maps nothing
    set_config(3'd3, 8'h00, 24'hFFFFFF, 24'hFFFFFF);
    repeat (2) begin
      a     = rand_bits(24);
      a[15] = 1'b1;
      bus_access(a, 8'h00, 8'h00, 1'b0);
    end
    // system area below 8000, outside save ram
    set_config(cart_pkg::map_hirom, 8'h00, 24'hFFFFFF, 24'hFFFFFF);
    repeat (2) begin
      a     = rand_bits(24);
      a[22] = 1'b0;
      a[15] = 1'b0;
      a[13] = 1'b0;
      bus_access(a, 8'h00, 8'h00, 1'b0);
    end
    end_test();
  endtask

  task automatic test_selects;
    logic [7:0] b;
    start_test("select pulses");
    armed = 1'b1;
    for (int pass = 0; pass < 2; pass++) begin
      // first pass with srtc, msu1 and 213f enabled, then all off
      set_config(cart_pkg::map_hirom, (pass == 0) ? 8'h1C : 8'h00, 24'hFFFFFF, 24'h0);
      b    = 8'(rand_bits(8));
      b[6] = 1'b0;
      bus_access({b, 13'h0400, 3'(rand_bits(3))}, 8'h00, 8'h00, 1'b0);
      bus_access({b, 15'h1400, 1'(rand_bits(1))}, 8'h00, 8'h00, 1'b0);
      bus_access({b, 16'h2100}, 8'h3f, 8'h00, 1'b0);
      if (pass == 0) begin
        bus_access({b, 16'h2100}, {4'hF, 4'(rand_bits(4))}, 8'h00, 1'b0);
        // write, so no rom request rides along
        bus_access({20'hCCCCC, 4'(rand_bits(4))}, 8'h00, 8'h5a, 1'b1);
      end
    end
    end_test();
  endtask

  task automatic test_backpressure;
    logic [23:0] a;
    logic [29:0] r;
    start_test("back-pressure");
    armed     = 1'b0;
    mem_ready = 1'b0;
    set_config(cart_pkg::map_hirom, 8'h00, 24'hFFFFFF, 24'h0);
    a     = rand_bits(24);
    a[15] = 1'b1;
    r     = ref_decode(cur_mapper, cur_features, cur_rom_mask, cur_sram_mask, a, 8'h00, 1'b0);
    bus_access(a, 8'h00, 8'h00, 1'b0);
    // request must hold while ready is low
    repeat (20) begin
      main_checks++;
      if (mem_valid !== 1'b1) begin
        flag_problem("pending request dropped without ready");
        main_errs++;
      end
      if (mem_addr !== r[28:5]) begin
        flag_mismatch("held mem_addr", r[28:5], mem_addr);
        main_errs++;
      end
      if (mem_we !== 1'b0) begin
        flag_mismatch("held mem_we", 24'h0, 24'(mem_we));
        main_errs++;
      end
      @(negedge clk);
    end
    // second rom read arrives while still pending
    a     = rand_bits(24);
    a[15] = 1'b1;
    bus_access(a, 8'h00, 8'h00, 1'b0);
    main_checks++;
    if (overrun !== 1'b1) begin
      flag_mismatch("overrun", 24'h1, 24'(overrun));
      main_errs++;
    end
    if (mem_addr !== r[28:5]) begin
      flag_mismatch("mem_addr after drop", r[28:5], mem_addr);
      main_errs++;
    end
    mem_ready = 1'b1;
    @(negedge clk);
    main_checks++;
    if (mem_valid !== 1'b0) begin
      flag_problem("request still valid after ready was given");
      main_errs++;
    end
    // sticky until reset
    if (overrun !== 1'b1) begin
      flag_mismatch("overrun after transfer", 24'h1, 24'(overrun));
      main_errs++;
    end
    end_test();
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    snes_addr   = '0;
    snes_pa     = '0;
    snes_wdata  = '0;
    snes_rd     = 1'b0;
    snes_wr     = 1'b0;
    cfg_we      = 1'b0;
    cfg_sel     = '0;
    cfg_wdata   = '0;
    mem_ready   = 1'b1;
    armed       = 1'b0;
    rise_cycle  = -100;
    exp_req     = 1'b0;
    exp_addr    = '0;
    exp_we      = 1'b0;
    exp_wdata   = '0;
    exp_sel     = '0;
    cmp_errs    = 0;
    cmp_checks  = 0;
    main_errs   = 0;
    main_checks = 0;
    errs_base   = 0;
    tests_run   = 0;
    // reset values of the config block
    cur_mapper    = cart_pkg::map_menu;
    cur_features  = '0;
    cur_rom_mask  = '0;
    cur_sram_mask = '0;
    wait (rst === 1'b0);
    @(negedge clk);
    test_idle();
    test_rom_reads();
    test_saveram();
    test_no_request();
    test_selects();
    test_backpressure();
    $display("%0d tests, %0d checks, %0d errors", tests_run,
             main_checks + cmp_checks, main_errs + cmp_errs);
    if (main_errs + cmp_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
common/cart_pkg.sv
logic/config_regs.sv
logic/bus_capture.sv
address/address.sv
logic/access_dispatch.sv
logic/cart_top.sv
tb/clock_gen.sv
tb/tb_cart_top.sv
